//--- bench/icacheBench.sv
// Instruction cache testbench
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icacheBench;
    import icachePkg::*;

    typedef struct packed {
        logic [15:0] addr;
        logic        hold;
        logic        expectHit;
    } stimRow_t;

    localparam int ROW_COUNT   = 22;
    localparam int HOLD_CYCLES = 3;
    localparam int CYCLE_LIMIT = ROW_COUNT * 40;

    // address, rspReady held back, expected hit
    localparam stimRow_t STIM_TABLE [ROW_COUNT] = '{
        '{16'h0000, 1'b0, 1'b0}, '{16'h0004, 1'b0, 1'b1}, '{16'h000C, 1'b1, 1'b1},
        '{16'h0010, 1'b0, 1'b0}, '{16'h0018, 1'b1, 1'b1}, '{16'h1200, 1'b0, 1'b0},
        '{16'h0008, 1'b0, 1'b0}, '{16'h1204, 1'b0, 1'b0}, '{16'h1208, 1'b1, 1'b1},
        '{16'h00F0, 1'b1, 1'b0}, '{16'h00FC, 1'b0, 1'b1}, '{16'hABC4, 1'b0, 1'b0},
        '{16'hABC0, 1'b0, 1'b1}, '{16'h5534, 1'b0, 1'b0}, '{16'h0014, 1'b0, 1'b1},
        '{16'h5538, 1'b1, 1'b1}, '{16'hFFF0, 1'b0, 1'b0}, '{16'h00F8, 1'b0, 1'b0},
        '{16'hFFFC, 1'b0, 1'b0}, '{16'h0007, 1'b0, 1'b0}, '{16'h0001, 1'b1, 1'b1},
        '{16'hABCE, 1'b0, 1'b1}
    };

    logic         clock;
    logic         reset;
    logic         reqValid;
    logic         reqReady;
    fetchAddr_t   reqAddr;
    logic         rspValid;
    logic         rspReady;
    instrWord_t   rspData;
    logic         memReqValid;
    logic         memReqReady;
    blockAddr_t   memReqBlockAddr;
    logic         memRspValid;
    icacheBlock_u memRspBlock;

    int                     errorCount  = 0;
    int                     cycleCount  = 0;
    int                     memReqCount = 0;
    logic [11:0]            lastBlockAddr;
    lineTag_t               modelTag [`LINE_COUNT];
    logic [`LINE_COUNT-1:0] modelValid;

    icacheTop icacheTop_inst (.*);

    memoryModel memoryModel_inst (.*);

    initial begin
        clock = 1'b0;
        forever begin
            #10 clock = ~clock;
        end
    end

    // memory request count and cycle limit
    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (memReqValid && memReqReady) begin
            memReqCount   <= memReqCount + 1;
            lastBlockAddr <= memReqBlockAddr;
        end
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Verification failed");
            $finish;
        end
    end

    // aligned word of byte address A is A * 9E3779B1 ^ 5A5A0000
    function automatic instrWord_t expectedWord(input logic [15:0] byteAddr);
        return ({16'h0000, byteAddr[15:2], 2'b00} * 32'h9E37_79B1) ^ 32'h5A5A_0000;
    endfunction

    function automatic logic predictHit(input fetchAddr_t addr);
        return modelValid[addr.index] && (modelTag[addr.index] == addr.tag);
    endfunction

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] want);
        errorCount++;
        $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, want);
    endtask

    task automatic runRow(input int row);
        fetchAddr_t addr;
        logic       hit;
        int         acceptCycle;
        int         latency;
        int         requestsBefore;
        instrWord_t want;
        addr = STIM_TABLE[row].addr;
        hit  = predictHit(addr);
        want = expectedWord(addr);
        assert (hit == STIM_TABLE[row].expectHit) else begin
            errorCount++;
            $display("Row %0d: table and reference model disagree on hit or miss", row);
        end
        requestsBefore = memReqCount;
        reqValid <= 1'b1;
        reqAddr  <= addr;
        rspReady <= !STIM_TABLE[row].hold;
        @(posedge clock);
        while (!reqReady) begin
            @(posedge clock);
        end
        acceptCycle = cycleCount;
        reqValid <= 1'b0;
        @(posedge clock);
        while (!rspValid) begin
            @(posedge clock);
        end
        // rspValid set one edge after acceptance shows up a sample later
        latency = cycleCount - acceptCycle - 1;
        if (hit) begin
            assert (latency == 1) else reportMismatch("hit latency", latency, 1);
            assert (memReqCount == requestsBefore) else
                reportMismatch("memReqCount", memReqCount, requestsBefore);
        end else begin
            assert (memReqCount == requestsBefore + 1) else
                reportMismatch("memReqCount", memReqCount, requestsBefore + 1);
            assert (lastBlockAddr == {addr.tag, addr.index}) else
                reportMismatch("memReqBlockAddr", 32'(lastBlockAddr),
                               32'({addr.tag, addr.index}));
        end
        assert (rspData == want) else reportMismatch("rspData", rspData, want);
        if (STIM_TABLE[row].hold) begin
            repeat (HOLD_CYCLES) begin
                @(posedge clock);
                assert (rspValid) else reportMismatch("rspValid", 32'(rspValid), 1);
                assert (rspData == want) else reportMismatch("rspData", rspData, want);
                assert (!reqReady) else reportMismatch("reqReady", 32'(reqReady), 0);
            end
            rspReady <= 1'b1;
            @(posedge clock);
            assert (rspValid) else reportMismatch("rspValid", 32'(rspValid), 1);
        end
        // response handshake completes on this edge
        assert (!reqReady) else reportMismatch("reqReady", 32'(reqReady), 0);
        if (!hit) begin
            modelValid[addr.index] = 1'b1;
            modelTag[addr.index]   = addr.tag;
        end
    endtask

    initial begin
        reset    <= 1'b0;
        reqValid <= 1'b0;
        reqAddr  <= '0;
        rspReady <= 1'b0;
        modelValid = '0;
        repeat (16) begin
            @(posedge clock);
        end
        assert (!reqReady && !rspValid && !memReqValid) else begin
            errorCount++;
            $display("Handshake outputs are not low while reset is held");
        end
        reset <= 1'b1;
        @(posedge clock);
        assert (!rspValid && !memReqValid) else begin
            errorCount++;
            $display("rspValid or memReqValid is high right after reset");
        end
        for (int row = 0; row < ROW_COUNT; row++) begin
            runRow(row);
        end
        $display("Checks done: %0d errors, %0d memory requests", errorCount, memReqCount);
        if (errorCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/memoryModel.sv
// Backing memory model
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module memoryModel (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    memReqValid,
    output logic                    memReqReady,
    input  icachePkg::blockAddr_t   memReqBlockAddr,
    output logic                    memRspValid,
    output icachePkg::icacheBlock_u memRspBlock
);
    import icachePkg::*;

    localparam logic [31:0] SEED = 32'h073c_6a04;

    logic [31:0] randState;
    blockAddr_t  blockHeld;

    function automatic logic [31:0] nextRandom(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // word at byte address A is A times 9E3779B1, xor 5A5A0000
    function automatic icacheBlock_u blockFor(input blockAddr_t block);
        icacheBlock_u result;
        logic [31:0]  byteAddr;
        for (int w = 0; w < `BLOCK_WORDS; w++) begin
            byteAddr = {16'h0000, block, w[1:0], 2'b00};
            result.words[w[1:0]] = (byteAddr * 32'h9E37_79B1) ^ 32'h5A5A_0000;
        end
        return result;
    endfunction

    initial begin
        memReqReady <= 1'b0;
        memRspValid <= 1'b0;
        memRspBlock <= '0;
        randState = SEED;
        wait (reset);
        forever begin
            @(posedge clock);
            if (memReqValid) begin
                // ready held back for 0 to 3 cycles
                randState = nextRandom(randState);
                repeat (randState[1:0]) begin
                    @(posedge clock);
                end
                memReqReady <= 1'b1;
                @(posedge clock);
                memReqReady <= 1'b0;
                blockHeld = memReqBlockAddr;
                // answer 1 to 8 cycles after the request handshake
                randState = nextRandom(randState);
                repeat (randState[2:0]) begin
                    @(posedge clock);
                end
                memRspValid <= 1'b1;
                memRspBlock <= blockFor(blockHeld);
                @(posedge clock);
                memRspValid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+rtl
rtl/icachePkg.sv
rtl/icacheArrayIf.sv
rtl/tagStore.sv
rtl/dataStore.sv
rtl/icacheController.sv
rtl/icacheTop.sv
bench/memoryModel.sv
bench/icacheBench.sv

//--- build.sh
#!/usr/bin/env bash
# build the cache and its testbench with Verilator, then run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f build.f --top-module icacheBench -o icacheSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

simOutput=$(./obj_dir/icacheSim)
simStatus=$?
echo "$simOutput"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOutput" | grep -qx "Verification passed"; then
    exit 0
fi
exit 1

//--- rtl/dataStore.sv
// Cache block data array
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module dataStore (
    input  logic       clock,
    icacheArrayIf.data arrays
);
    import icachePkg::*;

    icacheBlock_u blockArray [`LINE_COUNT];

    // whole block lands in one cycle
    always_ff @(posedge clock) begin
        if (arrays.fillEnable) begin
            blockArray[arrays.fillIndex].flat <= arrays.fillBlock.flat;
        end
    end

    // read on every edge, a fill on the same edge shows up one cycle later
    always_ff @(posedge clock) begin
        arrays.lineBlock <= blockArray[arrays.lookupIndex];
    end

endmodule

`default_nettype wire

//--- rtl/icacheArrayIf.sv
// Cache array interface
`timescale 1ns/1ps
`default_nettype none

interface icacheArrayIf;
    import icachePkg::*;

    // lookup side, index and tag are sampled by the arrays on every edge
    lineIndex_t   lookupIndex;
    lineTag_t     lookupTag;

    // line fill from the miss path
    logic         fillEnable;
    lineIndex_t   fillIndex;
    lineTag_t     fillTag;
    icacheBlock_u fillBlock;

    // registered array results
    logic         hit;
    icacheBlock_u lineBlock;

    modport control (
        output lookupIndex, lookupTag,
        output fillEnable, fillIndex, fillTag, fillBlock,
        input  hit, lineBlock
    );

    modport tags (
        input  lookupIndex, lookupTag,
        input  fillEnable, fillIndex, fillTag,
        output hit
    );

    modport data (
        input  lookupIndex,
        input  fillEnable, fillIndex, fillBlock,
        output lineBlock
    );

endinterface

`default_nettype wire

//--- rtl/icacheController.sv
// Instruction cache controller
`timescale 1ns/1ps
`default_nettype none

module icacheController (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    reqValid,
    output logic                    reqReady,
    input  icachePkg::fetchAddr_t   reqAddr,
    output logic                    rspValid,
    input  logic                    rspReady,
    output icachePkg::instrWord_t   rspData,
    output logic                    memReqValid,
    input  logic                    memReqReady,
    output icachePkg::blockAddr_t   memReqBlockAddr,
    input  logic                    memRspValid,
    input  icachePkg::icacheBlock_u memRspBlock,
    icacheArrayIf.control           arrays
);
    import icachePkg::*;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MEMREQ,
        MEMWAIT,
        FILL
    } state_t;

    state_t       state;
    state_t       nextState;
    fetchAddr_t   addrReg;
    icacheBlock_u fillBlockReg;
    logic         accept;
    logic         fillArrive;

    assign accept     = reqValid && reqReady;
    assign fillArrive = (state == MEMWAIT) && memRspValid;

    // arrays see the incoming address while idle, the held one afterwards
    assign arrays.lookupIndex = (state == IDLE) ? reqAddr.index : addrReg.index;
    assign arrays.lookupTag   = (state == IDLE) ? reqAddr.tag : addrReg.tag;

    assign arrays.fillIndex = addrReg.index;
    assign arrays.fillTag   = addrReg.tag;
    assign arrays.fillBlock = fillBlockReg;

    assign memReqBlockAddr = '{tag: addrReg.tag, index: addrReg.index};

    // response word comes from the line on a hit, from the fill block on a miss
    always_comb begin
        if (state == FILL) begin
            rspData = fillBlockReg.words[addrReg.wordOffset];
        end else begin
            rspData = arrays.lineBlock.words[addrReg.wordOffset];
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    nextState = LOOKUP;
                end
            end
            LOOKUP: begin
                // stay here while a hit response waits for its handshake
                if (rspValid) begin
                    if (rspReady) begin
                        nextState = IDLE;
                    end
                end else if (!arrays.hit) begin
                    nextState = MEMREQ;
                end
            end
            MEMREQ: begin
                if (memReqReady) begin
                    nextState = MEMWAIT;
                end
            end
            MEMWAIT: begin
                if (memRspValid) begin
                    nextState = FILL;
                end
            end
            FILL: begin
                if (rspReady) begin
                    nextState = IDLE;
                end
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state       <= IDLE;
            reqReady    <= 1'b0;
            rspValid    <= 1'b0;
            memReqValid <= 1'b0;
            arrays.fillEnable <= 1'b0;
        end else begin
            state       <= nextState;
            reqReady    <= (nextState == IDLE);
            memReqValid <= (nextState == MEMREQ);
            // single write pulse, even if FILL is held by back-pressure
            arrays.fillEnable <= fillArrive;
            if (rspValid && rspReady) begin
                rspValid <= 1'b0;
            end else if ((state == LOOKUP && arrays.hit) || fillArrive) begin
                rspValid <= 1'b1;
            end
        end
    end

    // held address and fill block
    always_ff @(posedge clock) begin
        if (accept) begin
            addrReg <= reqAddr;
        end
        if (fillArrive) begin
            fillBlockReg <= memRspBlock;
        end
    end

endmodule

`default_nettype wire

//--- rtl/icachePkg.sv
// Instruction cache types
`default_nettype none

`include "icache_defines.svh"

package icachePkg;

    typedef logic [`INDEX_BITS-1:0] lineIndex_t;
    typedef logic [`TAG_BITS-1:0] lineTag_t;
    typedef logic [`WORD_BITS-1:0] instrWord_t;

    // byte address as seen by the cache
    typedef struct packed {
        lineTag_t                      tag;
        lineIndex_t                    index;
        logic [`BLOCK_OFFSET_BITS-1:0] wordOffset;
        logic [`WORD_OFFSET_BITS-1:0]  byteOffset;
    } fetchAddr_t;

    // block number sent to the backing memory
    typedef struct packed {
        lineTag_t   tag;
        lineIndex_t index;
    } blockAddr_t;

    // word 0 sits in the lowest bits of the flat view
    typedef union packed {
        logic [`BLOCK_WORDS*`WORD_BITS-1:0] flat;
        instrWord_t [`BLOCK_WORDS-1:0]      words;
    } icacheBlock_u;

endpackage

`default_nettype wire

//--- rtl/icacheTop.sv
// Instruction cache top level
`timescale 1ns/1ps
`default_nettype none

module icacheTop (
    input  logic                    clock,
    input  logic                    reset,

    // fetch side
    input  logic                    reqValid,
    output logic                    reqReady,
    input  icachePkg::fetchAddr_t   reqAddr,
    output logic                    rspValid,
    input  logic                    rspReady,
    output icachePkg::instrWord_t   rspData,

    // backing memory side
    output logic                    memReqValid,
    input  logic                    memReqReady,
    output icachePkg::blockAddr_t   memReqBlockAddr,
    input  logic                    memRspValid,
    input  icachePkg::icacheBlock_u memRspBlock
);

    icacheArrayIf arrays ();

    tagStore tagStore_inst (
        .clock  (clock),
        .reset  (reset),
        .arrays (arrays)
    );

    dataStore dataStore_inst (
        .clock  (clock),
        .arrays (arrays)
    );

    icacheController icacheController_inst (
        .clock           (clock),
        .reset           (reset),
        .reqValid        (reqValid),
        .reqReady        (reqReady),
        .reqAddr         (reqAddr),
        .rspValid        (rspValid),
        .rspReady        (rspReady),
        .rspData         (rspData),
        .memReqValid     (memReqValid),
        .memReqReady     (memReqReady),
        .memReqBlockAddr (memReqBlockAddr),
        .memRspValid     (memRspValid),
        .memRspBlock     (memRspBlock),
        .arrays          (arrays)
    );

endmodule

`default_nettype wire

//--- rtl/icache_defines.svh
// Instruction cache sizes
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// fetch address and instruction word
`define ADDR_WIDTH 16
`define WORD_BITS 32

// block and line geometry
`define BLOCK_WORDS 4
`define LINE_COUNT 16

// address fields, byte offset in the lowest bits
`define WORD_OFFSET_BITS 2
`define BLOCK_OFFSET_BITS 2
`define INDEX_BITS 4
`define TAG_BITS (`ADDR_WIDTH - `INDEX_BITS - `BLOCK_OFFSET_BITS - `WORD_OFFSET_BITS)

`endif

//--- rtl/tagStore.sv
// Cache tag array
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module tagStore (
    input  logic       clock,
    input  logic       reset,
    icacheArrayIf.tags arrays
);
    import icachePkg::*;

    lineTag_t               tagArray [`LINE_COUNT];
    logic [`LINE_COUNT-1:0] validBits;
    lineTag_t               storedTag;
    logic                   storedValid;

    // current contents of the addressed line
    assign storedTag   = tagArray[arrays.lookupIndex];
    assign storedValid = validBits[arrays.lookupIndex];

    // tag written on the fill cycle
    always_ff @(posedge clock) begin
        if (arrays.fillEnable) begin
            tagArray[arrays.fillIndex] <= arrays.fillTag;
        end
    end

    // every line starts empty
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            validBits <= '0;
        end else if (arrays.fillEnable) begin
            validBits[arrays.fillIndex] <= 1'b1;
        end
    end

    // hit decision lines up with the registered data read
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            arrays.hit <= 1'b0;
        end else begin
            arrays.hit <= storedValid && (storedTag == arrays.lookupTag);
        end
    end

endmodule

`default_nettype wire
